/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_scope_ui
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* chart_drag.sv */
`timescale 1ns/1ps

module chart_drag
    import scope_ui_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  mouse_t     mouse,
    output chart_pan_t pan
);

    logic [11:0] anchor_x;
    logic [11:0] anchor_y;
    logic [11:0] anchor_x_nxt;
    logic [11:0] anchor_y_nxt;
    chart_pan_t  pan_nxt;
    logic        in_chart;
    logic        ge_x;
    logic        ge_y;
    logic [11:0] dist_x;
    logic [11:0] dist_y;

    ////////////////////////////////////////////////////////////////////////////
    // Window test and distance from anchor
    ////////////////////////////////////////////////////////////////////////////

    assign in_chart = (int'(mouse.xpos) >= CHART_X0)
                   && (int'(mouse.xpos) <= CHART_X0 + CHART_W)
                   && (int'(mouse.ypos) >= CHART_Y0)
                   && (int'(mouse.ypos) <= CHART_Y0 + CHART_H);

    assign ge_x   = (anchor_x >= mouse.xpos);
    assign ge_y   = (anchor_y >= mouse.ypos);
    assign dist_x = ge_x ? (anchor_x - mouse.xpos) : (mouse.xpos - anchor_x);
    assign dist_y = ge_y ? (anchor_y - mouse.ypos) : (mouse.ypos - anchor_y);

    always_comb begin
        anchor_x_nxt = anchor_x;
        anchor_y_nxt = anchor_y;
        pan_nxt      = pan;
        if (!in_chart) begin
            // Anchor follows the pointer until it enters the chart
            anchor_x_nxt = mouse.xpos;
            anchor_y_nxt = mouse.ypos;
        end else if (mouse.left) begin
            pan_nxt.dx      = dist_x[10:0];
            pan_nxt.dy      = dist_y[10:0];
            pan_nxt.minus_x = ge_x;
            pan_nxt.minus_y = ge_y;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            anchor_x <= '0;
            anchor_y <= '0;
            pan      <= '0;
        end else begin
            anchor_x <= anchor_x_nxt;
            anchor_y <= anchor_y_nxt;
            pan      <= pan_nxt;
        end
    end

endmodule

/* filelist.f */
scope_ui_pkg.sv
scope_cfg_pkg.sv
chart_drag.sv
setting_adjust.sv
scope_ui_top.sv
scope_ui_sva.sv
tb_scope_ui.sv

/* scope_cfg_pkg.sv */
package scope_cfg_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Scope settings
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [11:0] trig_level;
        logic [11:0] adc_rate;
        logic [11:0] trig_div;
    } scope_settings_t;

    localparam scope_settings_t SETTINGS_RESET = '{
        trig_level: 12'd3071,
        adc_rate:   12'd31,
        trig_div:   12'd3
    };

    // Saturation limits
    localparam logic [11:0] TRIG_MIN = 12'd2055;
    localparam logic [11:0] TRIG_MAX = 12'd4000;
    localparam logic [11:0] ADC_MIN  = 12'd13;
    localparam logic [11:0] ADC_MAX  = 12'd4095;
    localparam logic [11:0] DIV_MIN  = 12'd0;
    localparam logic [11:0] DIV_MAX  = 12'd4095;

    ////////////////////////////////////////////////////////////////////////////
    // Click zones along x
    ////////////////////////////////////////////////////////////////////////////

    // Divider below DIV_END, trigger up to TRIG_END, ADC rate up to ADC_END
    // All bounds are exclusive
    localparam logic [11:0] ZONE_DIV_END  = 12'd100;
    localparam logic [11:0] ZONE_TRIG_END = 12'd500;
    localparam logic [11:0] ZONE_ADC_END  = 12'd1000;

endpackage

/* scope_ui_pkg.sv */
package scope_ui_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Pointer input
    ////////////////////////////////////////////////////////////////////////////

    // Position in screen pixels and the three button levels
    typedef struct packed {
        logic [11:0] xpos;
        logic [11:0] ypos;
        logic        left;
        logic        right;
        logic        middle;
    } mouse_t;

    ////////////////////////////////////////////////////////////////////////////
    // Chart pan
    ////////////////////////////////////////////////////////////////////////////

    // Magnitude per axis, sign set when anchor >= pointer
    typedef struct packed {
        logic [10:0] dx;
        logic [10:0] dy;
        logic        minus_x;
        logic        minus_y;
    } chart_pan_t;

    // Chart window, inclusive on every edge
    localparam int CHART_X0 = 150;
    localparam int CHART_W  = 800;
    localparam int CHART_Y0 = 100;
    localparam int CHART_H  = 400;

endpackage

/* scope_ui_sva.sv */
`timescale 1ns/1ps

module scope_ui_sva
    import scope_cfg_pkg::*;
(
    input logic            clk,
    input logic            rst,
    input logic            hold_state,
    input scope_settings_t settings
);

    // Every field inside its saturation range
    limits_ok: assert property (@(posedge clk) disable iff (rst)
        settings.trig_level >= TRIG_MIN && settings.trig_level <= TRIG_MAX
        && settings.adc_rate >= ADC_MIN && settings.adc_rate <= ADC_MAX
        && settings.trig_div >= DIV_MIN && settings.trig_div <= DIV_MAX)
        else $error("setting field outside its limits");

    // Hold-off freezes the settings
    hold_frozen: assert property (@(posedge clk) disable iff (rst)
        hold_state |=> $stable(settings))
        else $error("settings changed during hold-off");

    // A change comes from an idle click and touches one field only
    one_field: assert property (@(posedge clk) disable iff (rst)
        !$stable(settings) |-> !$past(hold_state)
            && ($countones({settings.trig_level != $past(settings.trig_level),
                            settings.adc_rate != $past(settings.adc_rate),
                            settings.trig_div != $past(settings.trig_div)}) <= 1))
        else $error("more than one setting changed on one click");

endmodule

bind setting_adjust scope_ui_sva u_scope_ui_sva (
    .clk        (clk),
    .rst        (rst),
    .hold_state (state == ST_HOLD),
    .settings   (settings)
);

/* scope_ui_top.sv */
`timescale 1ns/1ps

module scope_ui_top
    import scope_ui_pkg::*;
    import scope_cfg_pkg::*;
#(
    parameter int HOLD_CYCLES = 100000
) (
    input  logic            clk,
    input  logic            rst,
    input  mouse_t          mouse,
    output chart_pan_t      pan,
    output scope_settings_t settings
);

    ////////////////////////////////////////////////////////////////////////////
    // Chart drag
    ////////////////////////////////////////////////////////////////////////////

    // Left drag inside the chart window pans the trace
    chart_drag u_chart_drag (
        .clk   (clk),
        .rst   (rst),
        .mouse (mouse),
        .pan   (pan)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Setting clicks
    ////////////////////////////////////////////////////////////////////////////

    // Trigger level, ADC rate and trigger divider
    setting_adjust #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_setting_adjust (
        .clk      (clk),
        .rst      (rst),
        .mouse    (mouse),
        .settings (settings)
    );

endmodule

/* setting_adjust.sv */
`timescale 1ns/1ps

module setting_adjust
    import scope_ui_pkg::*;
    import scope_cfg_pkg::*;
#(
    parameter int HOLD_CYCLES = 100000
) (
    input  logic            clk,
    input  logic            rst,
    input  mouse_t          mouse,
    output scope_settings_t settings
);

    localparam int CNT_W = (HOLD_CYCLES > 0) ? $clog2(HOLD_CYCLES + 1) : 1;

    typedef enum logic {
        ST_IDLE,
        ST_HOLD
    } state_t;

    state_t          state;
    state_t          state_nxt;
    logic [CNT_W-1:0] hold_cnt;
    logic [CNT_W-1:0] hold_cnt_nxt;
    scope_settings_t settings_nxt;

    logic in_adc;
    logic in_trig;
    logic in_div;
    logic any_btn;
    logic up;

    // Step by one toward the limit, stay put once there
    function automatic logic [11:0] sat_step(
        input logic [11:0] val,
        input logic        inc,
        input logic [11:0] lo,
        input logic [11:0] hi
    );
        logic [11:0] res;
        if (inc) begin
            res = (val >= hi) ? hi : val + 12'd1;
        end else begin
            res = (val <= lo) ? lo : val - 12'd1;
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Zone and button decode
    ////////////////////////////////////////////////////////////////////////////

    assign in_adc  = mouse.middle && (mouse.xpos > ZONE_TRIG_END)
                                  && (mouse.xpos < ZONE_ADC_END);
    assign in_trig = mouse.middle && (mouse.xpos > ZONE_DIV_END)
                                  && (mouse.xpos < ZONE_TRIG_END);
    // No middle button needed here
    assign in_div  = (mouse.xpos < ZONE_DIV_END);

    assign any_btn = mouse.right || mouse.left;
    // Right wins when both are down
    assign up      = mouse.right;

    ////////////////////////////////////////////////////////////////////////////
    // Click acceptance and hold-off
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt    = state;
        hold_cnt_nxt = hold_cnt;
        settings_nxt = settings;
        case (state)
            ST_IDLE: begin
                if (any_btn && in_adc) begin
                    settings_nxt.adc_rate = sat_step(settings.adc_rate, up,
                                                     ADC_MIN, ADC_MAX);
                    state_nxt = ST_HOLD;
                end else if (any_btn && in_trig) begin
                    settings_nxt.trig_level = sat_step(settings.trig_level, up,
                                                       TRIG_MIN, TRIG_MAX);
                    state_nxt = ST_HOLD;
                end else if (any_btn && in_div) begin
                    settings_nxt.trig_div = sat_step(settings.trig_div, up,
                                                     DIV_MIN, DIV_MAX);
                    state_nxt = ST_HOLD;
                end
            end
            ST_HOLD: begin
                // HOLD_CYCLES + 1 clocks here, buttons ignored
                if (hold_cnt == CNT_W'(HOLD_CYCLES)) begin
                    hold_cnt_nxt = '0;
                    state_nxt    = ST_IDLE;
                end else begin
                    hold_cnt_nxt = hold_cnt + 1'b1;
                end
            end
            default: begin
                hold_cnt_nxt = '0;
                state_nxt    = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            hold_cnt <= '0;
            settings <= SETTINGS_RESET;
        end else begin
            state    <= state_nxt;
            hold_cnt <= hold_cnt_nxt;
            settings <= settings_nxt;
        end
    end

endmodule

/* tb_scope_ui.sv */
`timescale 1ns/1ps

module tb_scope_ui
    import scope_ui_pkg::*;
    import scope_cfg_pkg::*;
();

    localparam int HOLD          = 6;
    localparam int CLICK_PERIOD  = HOLD + 2;
    localparam int RESET_CYCLES  = 16;
    localparam int RANDOM_CYCLES = 3000;
    // Enough clicks to run each setting into its limit with a few spare
    localparam int TRIG_CLICKS   = int'(SETTINGS_RESET.trig_level) - int'(TRIG_MIN) + 4;
    localparam int DIV_CLICKS    = int'(DIV_MAX) - int'(SETTINGS_RESET.trig_div) + 4;
    localparam int TEST_CYCLES   = RESET_CYCLES + 400 + RANDOM_CYCLES
                                 + (TRIG_CLICKS + DIV_CLICKS) * CLICK_PERIOD;
    localparam longint TIMEOUT_NS = longint'(TEST_CYCLES) * 40 + 20000;

    logic            clk;
    logic            rst;
    mouse_t          mouse;
    chart_pan_t      pan;
    scope_settings_t settings;

    int errors;
    int checks;

    // Reference model state
    logic [11:0]     m_anchor_x;
    logic [11:0]     m_anchor_y;
    chart_pan_t      m_pan;
    scope_settings_t m_settings;
    int              m_hold_left;
    bit              m_accepted;
    bit              model_live;

    scope_ui_top #(
        .HOLD_CYCLES (HOLD)
    ) u_scope_ui_top (
        .clk      (clk),
        .rst      (rst),
        .mouse    (mouse),
        .pan      (pan),
        .settings (settings)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference functions
    ////////////////////////////////////////////////////////////////////////////

    function automatic bit in_window(input mouse_t m);
        return (m.xpos >= 150) && (m.xpos <= 950) && (m.ypos >= 100) && (m.ypos <= 500);
    endfunction

    function automatic chart_pan_t ref_pan(input logic [11:0] ax, input logic [11:0] ay,
                                           input mouse_t m, input chart_pan_t prev);
        chart_pan_t res;
        int         diff_x;
        int         diff_y;
        res    = prev;
        diff_x = int'(ax) - int'(m.xpos);
        diff_y = int'(ay) - int'(m.ypos);
        if (in_window(m) && m.left) begin
            res.minus_x = (diff_x >= 0);
            res.minus_y = (diff_y >= 0);
            res.dx      = 11'((diff_x < 0) ? -diff_x : diff_x);
            res.dy      = 11'((diff_y < 0) ? -diff_y : diff_y);
        end
        return res;
    endfunction

    // One step up or down clamped to [lo, hi]
    function automatic logic [11:0] bump(input logic [11:0] val, input bit inc,
                                         input logic [11:0] lo, input logic [11:0] hi);
        int v;
        v = int'(val) + (inc ? 1 : -1);
        if (v > int'(hi)) v = int'(hi);
        if (v < int'(lo)) v = int'(lo);
        return 12'(v);
    endfunction

    function automatic scope_settings_t ref_step(input scope_settings_t prev,
                                                 input mouse_t m, output bit accepted);
        scope_settings_t res;
        int              x;
        bit              click;
        res      = prev;
        x        = int'(m.xpos);
        click    = m.left || m.right;
        accepted = 1'b0;
        if (click && m.middle && x > 500 && x < 1000) begin
            res.adc_rate = bump(prev.adc_rate, m.right, ADC_MIN, ADC_MAX);
            accepted     = 1'b1;
        end else if (click && m.middle && x > 100 && x < 500) begin
            res.trig_level = bump(prev.trig_level, m.right, TRIG_MIN, TRIG_MAX);
            accepted       = 1'b1;
        end else if (click && x < 100) begin
            res.trig_div = bump(prev.trig_div, m.right, DIV_MIN, DIV_MAX);
            accepted     = 1'b1;
        end
        return res;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s expected 0x%0h got 0x%0h at %0t ns", name, expected, actual,
                     $time);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Cycle comparison
    ////////////////////////////////////////////////////////////////////////////

    // Outputs still hold their pre-edge values here
    always @(posedge clk) begin
        if (model_live) begin
            check_value("pan", 64'(m_pan), 64'(pan));
            check_value("settings", 64'(m_settings), 64'(settings));
        end
        if (rst) begin
            m_anchor_x  = '0;
            m_anchor_y  = '0;
            m_pan       = '0;
            m_settings  = SETTINGS_RESET;
            m_hold_left = 0;
            model_live  = 1'b1;
        end else begin
            m_pan = ref_pan(m_anchor_x, m_anchor_y, mouse, m_pan);
            if (!in_window(mouse)) begin
                m_anchor_x = mouse.xpos;
                m_anchor_y = mouse.ypos;
            end
            if (m_hold_left > 0) begin
                m_hold_left--;
            end else begin
                m_settings = ref_step(m_settings, mouse, m_accepted);
                if (m_accepted) m_hold_left = HOLD + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic set_mouse(input int x, input int y, input bit l, input bit r, input bit m);
        @(negedge clk);
        mouse.xpos   = 12'(x);
        mouse.ypos   = 12'(y);
        mouse.left   = l;
        mouse.right  = r;
        mouse.middle = m;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Park outside every zone until the hold-off has run out
    task automatic release_all();
        set_mouse(1100, 650, 0, 0, 0);
        wait_cycles(CLICK_PERIOD);
    endtask

    task automatic try_no_effect(input int x, input bit l, input bit r, input bit m);
        scope_settings_t snap;
        release_all();
        snap = settings;
        set_mouse(x, 650, l, r, m);
        wait_cycles(2 * CLICK_PERIOD);
        check_value("settings", 64'(snap), 64'(settings));
    endtask

    task automatic drag_case(input int ax, input int ay, input int px, input int py);
        chart_pan_t expected;
        mouse_t     probe;
        set_mouse(ax, ay, 0, 0, 0);
        set_mouse(px, py, 1, 0, 0);
        wait_cycles(1);
        probe    = mouse;
        expected = ref_pan(12'(ax), 12'(ay), probe, '0);
        check_value("pan", 64'(expected), 64'(pan));
        // Pan must hold once left is released
        set_mouse(px + 7, py + 5, 0, 0, 0);
        wait_cycles(2);
        check_value("pan", 64'(expected), 64'(pan));
    endtask

    initial begin
        scope_settings_t snap;
        logic [11:0]     start;
        errors   = 0;
        checks   = 0;
        void'($urandom(11));
        rst      = 1'b1;
        mouse    = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        check_value("settings", 64'(SETTINGS_RESET), 64'(settings));
        check_value("pan", 64'(0), 64'(pan));

        // ADC rate steps up once per click period while held
        release_all();
        snap  = settings;
        start = settings.adc_rate;
        set_mouse(700, 650, 0, 1, 1);
        for (int k = 0; k <= 2 * CLICK_PERIOD; k++) begin
            wait_cycles(1);
            check_value("adc_rate", 64'(start + 1 + k / CLICK_PERIOD), 64'(settings.adc_rate));
        end
        check_value("trig_level", 64'(snap.trig_level), 64'(settings.trig_level));
        check_value("trig_div", 64'(snap.trig_div), 64'(settings.trig_div));

        // Saturation at the lower trigger limit
        release_all();
        snap = settings;
        set_mouse(300, 650, 1, 0, 1);
        wait_cycles(TRIG_CLICKS * CLICK_PERIOD);
        check_value("trig_level", 64'(TRIG_MIN), 64'(settings.trig_level));
        check_value("adc_rate", 64'(snap.adc_rate), 64'(settings.adc_rate));
        check_value("trig_div", 64'(snap.trig_div), 64'(settings.trig_div));

        // Saturation at the upper divider limit without middle
        release_all();
        snap = settings;
        set_mouse(50, 650, 0, 1, 0);
        wait_cycles(DIV_CLICKS * CLICK_PERIOD);
        check_value("trig_div", 64'(DIV_MAX), 64'(settings.trig_div));
        check_value("trig_level", 64'(snap.trig_level), 64'(settings.trig_level));
        check_value("adc_rate", 64'(snap.adc_rate), 64'(settings.adc_rate));

        // Clicks that must be ignored since zone edges are exclusive
        try_no_effect(300, 0, 1, 0);
        try_no_effect(700, 1, 0, 0);
        try_no_effect(1500, 0, 1, 1);
        try_no_effect(100, 0, 1, 1);
        try_no_effect(100, 1, 0, 1);
        try_no_effect(500, 0, 1, 1);
        try_no_effect(1000, 0, 1, 1);

        // Drags into the chart from several anchors
        drag_case(120, 80, 400, 300);
        drag_case(1000, 600, 900, 450);
        drag_case(60, 300, 950, 100);
        drag_case(150, 50, 150, 250);

        // Random traffic checked cycle by cycle against the model
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            set_mouse($urandom_range(0, 1199), $urandom_range(0, 699),
                      $urandom_range(0, 2) == 0, $urandom_range(0, 3) == 0,
                      $urandom_range(0, 1) == 0);
        end
        wait_cycles(4);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: tests did not finish within %0d ns, errors so far: %0d",
                 TIMEOUT_NS, errors);
        $display("Simulation failed");
        $finish;
    end

endmodule
